/* common/sdlx_macros.svh */
`ifndef SDLX_MACROS_SVH
`define SDLX_MACROS_SVH

// ************************************************************
// datapath sizes shared by the packages and the RTL
// ************************************************************

// width of one register and of every ALU operand
`define SDLX_DATA_BITS 32

// register index width, enough for eight registers
`define SDLX_REG_BITS 3

// register count including the hardwired zero register
`define SDLX_NUM_REGS 8

`endif

/* common/sdlxIsaPkg.sv */
`include "sdlx_macros.svh"

package sdlxIsaPkg;

        // primary opcodes, any code not listed here is illegal
        typedef enum logic [5:0] {
                opAdd  = 6'h01,
                opSub  = 6'h02,
                opAnd  = 6'h03,
                opOr   = 6'h04,
                opXor  = 6'h05,
                // signed compare
                opSlt  = 6'h06,
                opSll  = 6'h07,
                opSrl  = 6'h08,
                opAddi = 6'h09,
                // imm goes to the upper half
                opLhi  = 6'h0A
        } opcode_e;

        // instruction word layout, msb first
        typedef struct packed {
                opcode_e                  opcode;
                logic [`SDLX_REG_BITS-1:0] rd;
                logic [`SDLX_REG_BITS-1:0] rs1;
                logic [`SDLX_REG_BITS-1:0] rs2;
                // reserved, ignored by decode
                logic                     spare;
                logic [15:0]              imm;
        } instrFields_t;

endpackage

/* common/sdlxPipePkg.sv */
`include "sdlx_macros.svh"

package sdlxPipePkg;

        // operation the execute stage performs
        typedef enum logic [3:0] {
                aluAdd,
                aluSub,
                aluAnd,
                aluOr,
                aluXor,
                aluSlt,
                aluSll,
                aluSrl,
                // result is operand B unchanged, used by lhi
                aluPassB
        } aluOp_e;

        // ************************************************************
        // decode -> execute
        // ************************************************************
        typedef struct packed {
                logic                      valid;
                aluOp_e                    aluOp;
                logic [`SDLX_REG_BITS-1:0]  rd;
                // already low for rd == 0
                logic                      wrEn;
                // source indices kept for forwarding compares
                logic [`SDLX_REG_BITS-1:0]  rs1;
                logic [`SDLX_REG_BITS-1:0]  rs2;
                logic                      useImm;
                // register file values captured at decode
                logic [`SDLX_DATA_BITS-1:0] opA;
                logic [`SDLX_DATA_BITS-1:0] opB;
                logic [`SDLX_DATA_BITS-1:0] imm32;
        } decodedOp_t;

        // execute -> result
        typedef struct packed {
                logic                      valid;
                logic [`SDLX_REG_BITS-1:0]  rd;
                logic                      wrEn;
                logic [`SDLX_DATA_BITS-1:0] value;
        } exResult_t;

        // committed result, also the top level trace
        typedef struct packed {
                logic                      valid;
                logic [`SDLX_REG_BITS-1:0]  rd;
                logic                      wrEn;
                logic [`SDLX_DATA_BITS-1:0] value;
        } wbTrace_t;

endpackage

/* regFile/regFile.sv */
`timescale 1ns/1ps
`include "sdlx_macros.svh"

module regFile (
        input  logic                       Clk,
        input  logic                       rstN,
        input  logic [`SDLX_REG_BITS-1:0]  rdReg1,
        input  logic [`SDLX_REG_BITS-1:0]  rdReg2,
        input  logic [`SDLX_REG_BITS-1:0]  wrtReg,
        input  logic [`SDLX_DATA_BITS-1:0] wrtData,
        input  logic                       regWrite,
        output logic [`SDLX_DATA_BITS-1:0] r1Out,
        output logic [`SDLX_DATA_BITS-1:0] r2Out
);

        // storage for r1..r7 only, r0 has no flops
        logic [`SDLX_DATA_BITS-1:0] regs [1:`SDLX_NUM_REGS-1];

        // full read view, entry 0 tied to zero
        logic [`SDLX_DATA_BITS-1:0] regView [`SDLX_NUM_REGS];

        // write port, index 0 never matches a storage slot
        always_ff @(posedge Clk or negedge rstN) begin
                if (!rstN) begin
                        for (int i = 1; i < `SDLX_NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else begin
                        for (int i = 1; i < `SDLX_NUM_REGS; i++) begin
                                if (regWrite && (wrtReg == `SDLX_REG_BITS'(i))) begin
                                        regs[i] <= wrtData;
                                end
                        end
                end
        end

        always_comb begin
                regView[0] = '0;
                for (int i = 1; i < `SDLX_NUM_REGS; i++) begin
                        regView[i] = regs[i];
                end
        end

        // two independent combinational read muxes
        assign r1Out = regView[rdReg1];
        assign r2Out = regView[rdReg2];

endmodule

/* logic/instDecode.sv */
`timescale 1ns/1ps
`include "sdlx_macros.svh"

module instDecode (
        input  logic                       Clk,
        input  logic                       rstN,
        input  logic [`SDLX_DATA_BITS-1:0] instr,
        input  logic                       instrValid,
        output logic [`SDLX_REG_BITS-1:0]  rdReg1,
        output logic [`SDLX_REG_BITS-1:0]  rdReg2,
        input  logic [`SDLX_DATA_BITS-1:0] r1Out,
        input  logic [`SDLX_DATA_BITS-1:0] r2Out,
        output sdlxPipePkg::decodedOp_t    decOp,
        output logic                       illegalInstr
);

        import sdlxIsaPkg::*;
        import sdlxPipePkg::*;

        instrFields_t fields;
        decodedOp_t   decNext;
        logic         legal;

        // ************************************************************
        // field split and register file read
        // ************************************************************
        assign fields = instrFields_t'(instr);

        // register file is read in the same cycle the instruction is presented
        assign rdReg1 = fields.rs1;
        assign rdReg2 = fields.rs2;

        // opcode -> alu op, immediate select, immediate form
        always_comb begin
                decNext        = '0;
                legal          = 1'b1;
                decNext.aluOp  = aluAdd;
                decNext.useImm = 1'b0;
                // sign extended by default, only lhi differs
                decNext.imm32  = {{(`SDLX_DATA_BITS-16){fields.imm[15]}}, fields.imm};
                case (fields.opcode)
                        opAdd: decNext.aluOp = aluAdd;
                        opSub: decNext.aluOp = aluSub;
                        opAnd: decNext.aluOp = aluAnd;
                        opOr:  decNext.aluOp = aluOr;
                        opXor: decNext.aluOp = aluXor;
                        opSlt: decNext.aluOp = aluSlt;
                        opSll: decNext.aluOp = aluSll;
                        opSrl: decNext.aluOp = aluSrl;
                        opAddi: begin
                                decNext.aluOp  = aluAdd;
                                decNext.useImm = 1'b1;
                        end
                        opLhi: begin
                                // imm in the upper half, low half zero
                                decNext.aluOp  = aluPassB;
                                decNext.useImm = 1'b1;
                                decNext.imm32  = {fields.imm, 16'h0000};
                        end
                        default: legal = 1'b0;
                endcase

                decNext.valid = instrValid && legal;
                // r0 writes are dropped here and nowhere else
                decNext.wrEn  = instrValid && legal && (fields.rd != '0);
                decNext.rd    = fields.rd;
                decNext.rs1   = fields.rs1;
                decNext.rs2   = fields.rs2;
                decNext.opA   = r1Out;
                decNext.opB   = r2Out;
        end

        // edge 1, control bits reset, operands are plain payload
        always_ff @(posedge Clk or negedge rstN) begin
                if (!rstN) begin
                        decOp.valid  <= 1'b0;
                        decOp.wrEn   <= 1'b0;
                        illegalInstr <= 1'b0;
                end else begin
                        decOp        <= decNext;
                        // one cycle pulse, the op itself travels on as invalid
                        illegalInstr <= instrValid && !legal;
                end
        end

endmodule

/* logic/aluExec.sv */
`timescale 1ns/1ps
`include "sdlx_macros.svh"

module aluExec (
        input  logic                    Clk,
        input  logic                    rstN,
        input  sdlxPipePkg::decodedOp_t decOp,
        input  sdlxPipePkg::wbTrace_t   wbTrace,
        output sdlxPipePkg::exResult_t  exRes
);

        import sdlxPipePkg::*;

        logic [`SDLX_DATA_BITS-1:0] srcA;
        logic [`SDLX_DATA_BITS-1:0] srcB;
        logic [`SDLX_DATA_BITS-1:0] opB;
        logic [`SDLX_DATA_BITS-1:0] aluOut;

        // ************************************************************
        // operand forwarding
        // ************************************************************

        // newest producer wins: own result reg first, then the trace reg
        function automatic logic [`SDLX_DATA_BITS-1:0] fwdSel(
                input logic [`SDLX_REG_BITS-1:0]  idx,
                input logic [`SDLX_DATA_BITS-1:0] captured
        );
                logic [`SDLX_DATA_BITS-1:0] sel;
                sel = captured;
                // wrEn is never set for rd 0, so r0 is never forwarded
                if (exRes.wrEn && (exRes.rd == idx)) begin
                        sel = exRes.value;
                end else if (wbTrace.wrEn && (wbTrace.rd == idx)) begin
                        sel = wbTrace.value;
                end
                return sel;
        endfunction

        always_comb begin
                srcA = fwdSel(decOp.rs1, decOp.opA);
                srcB = fwdSel(decOp.rs2, decOp.opB);
        end

        // immediate replaces B for addi and lhi
        assign opB = decOp.useImm ? decOp.imm32 : srcB;

        // ************************************************************
        // ALU
        // ************************************************************
        always_comb begin
                case (decOp.aluOp)
                        aluAdd:   aluOut = srcA + opB;
                        aluSub:   aluOut = srcA - opB;
                        aluAnd:   aluOut = srcA & opB;
                        aluOr:    aluOut = srcA | opB;
                        aluXor:   aluOut = srcA ^ opB;
                        // signed compare, result is 0 or 1
                        aluSlt:   aluOut = {{(`SDLX_DATA_BITS-1){1'b0}},
                                            ($signed(srcA) < $signed(opB))};
                        // shift amount from the low 5 bits of B
                        aluSll:   aluOut = srcA << opB[4:0];
                        aluSrl:   aluOut = srcA >> opB[4:0];
                        aluPassB: aluOut = opB;
                        default:  aluOut = '0;
                endcase
        end

        // edge 2, valid and wrEn reset, rd and value carried as payload
        always_ff @(posedge Clk or negedge rstN) begin
                if (!rstN) begin
                        exRes.valid <= 1'b0;
                        exRes.wrEn  <= 1'b0;
                end else begin
                        exRes.valid <= decOp.valid;
                        exRes.wrEn  <= decOp.wrEn;
                        exRes.rd    <= decOp.rd;
                        exRes.value <= aluOut;
                end
        end

endmodule

/* logic/resultWrite.sv */
`timescale 1ns/1ps
`include "sdlx_macros.svh"

module resultWrite (
        input  logic                       Clk,
        input  logic                       rstN,
        input  sdlxPipePkg::exResult_t     exRes,
        output logic [`SDLX_REG_BITS-1:0]  wrtReg,
        output logic [`SDLX_DATA_BITS-1:0] wrtData,
        output logic                       regWrite,
        output sdlxPipePkg::wbTrace_t      wbTrace
);

        import sdlxPipePkg::*;

        wbTrace_t traceNext;

        // register file write, lands on edge 3
        assign wrtReg   = exRes.rd;
        assign wrtData  = exRes.value;
        assign regWrite = exRes.valid && exRes.wrEn;

        always_comb begin
                traceNext.valid = exRes.valid;
                traceNext.rd    = exRes.rd;
                // wrEn low here marks a trace without a register write
                traceNext.wrEn  = exRes.valid && exRes.wrEn;
                traceNext.value = exRes.value;
        end

        // trace reg doubles as the second forwarding level
        always_ff @(posedge Clk or negedge rstN) begin
                if (!rstN) begin
                        wbTrace.valid <= 1'b0;
                        wbTrace.wrEn  <= 1'b0;
                end else begin
                        wbTrace <= traceNext;
                end
        end

endmodule

/* logic/sdlxCore.sv */
`timescale 1ns/1ps
`include "sdlx_macros.svh"

module sdlxCore (
        input  logic                       Clk,
        input  logic                       rstN,
        input  logic [`SDLX_DATA_BITS-1:0] instr,
        input  logic                       instrValid,
        output logic                       wbValid,
        output logic [`SDLX_REG_BITS-1:0]  wbReg,
        output logic [`SDLX_DATA_BITS-1:0] wbData,
        output logic                       illegalInstr
);

        import sdlxPipePkg::*;

        // ************************************************************
        // stage to stage and register file nets
        // ************************************************************
        logic [`SDLX_REG_BITS-1:0]  rdReg1;
        logic [`SDLX_REG_BITS-1:0]  rdReg2;
        logic [`SDLX_DATA_BITS-1:0] r1Out;
        logic [`SDLX_DATA_BITS-1:0] r2Out;
        logic [`SDLX_REG_BITS-1:0]  wrtReg;
        logic [`SDLX_DATA_BITS-1:0] wrtData;
        logic                       regWrite;
        decodedOp_t                 decOp;
        exResult_t                  exRes;
        wbTrace_t                   wbTrace;

        // decode, reads the register file
        instDecode uDecode (
                .Clk(Clk),
                .rstN(rstN),
                .instr(instr),
                .instrValid(instrValid),
                .rdReg1(rdReg1),
                .rdReg2(rdReg2),
                .r1Out(r1Out),
                .r2Out(r2Out),
                .decOp(decOp),
                .illegalInstr(illegalInstr)
        );

        regFile uRegFile (
                .Clk(Clk),
                .rstN(rstN),
                .rdReg1(rdReg1),
                .rdReg2(rdReg2),
                .wrtReg(wrtReg),
                .wrtData(wrtData),
                .regWrite(regWrite),
                .r1Out(r1Out),
                .r2Out(r2Out)
        );

        // execute gets the trace back for forwarding
        aluExec uExec (
                .Clk(Clk),
                .rstN(rstN),
                .decOp(decOp),
                .wbTrace(wbTrace),
                .exRes(exRes)
        );

        resultWrite uResult (
                .Clk(Clk),
                .rstN(rstN),
                .exRes(exRes),
                .wrtReg(wrtReg),
                .wrtData(wrtData),
                .regWrite(regWrite),
                .wbTrace(wbTrace)
        );

        // trace out to the pins
        assign wbValid = wbTrace.valid;
        assign wbReg   = wbTrace.rd;
        assign wbData  = wbTrace.value;

endmodule

/* test/sdlxCore_sva.sv */
`timescale 1ns/1ps
`include "sdlx_macros.svh"

module sdlxCore_sva (
        input logic                       Clk,
        input logic                       rstN,
        input logic [`SDLX_DATA_BITS-1:0] instr,
        input logic                       instrValid,
        input logic                       wbValid,
        input logic [`SDLX_REG_BITS-1:0]  wbReg,
        input logic                       wbWrEn,
        input logic                       illegalInstr,
        input logic                       regWrite,
        input logic [`SDLX_REG_BITS-1:0]  wrtReg
);

        logic legalOp;

        // defined opcodes are 0x01..0x0A
        assign legalOp = (instr[31:26] >= 6'h01) && (instr[31:26] <= 6'h0A);

        // ************************************************************
        // pipeline timing
        // ************************************************************

        // legal issue gives a trace three edges later
        aLegalTrace: assert property (@(posedge Clk) disable iff (!rstN)
                $past(instrValid && legalOp, 3) |-> wbValid)
                else $error("legal instruction lost its trace");

        aIllegalNoTrace: assert property (@(posedge Clk) disable iff (!rstN)
                $past(instrValid && !legalOp, 3) |-> !wbValid)
                else $error("illegal instruction produced a trace");

        // one cycle pulse exactly one edge after sampling
        aIllegalPulse: assert property (@(posedge Clk) disable iff (!rstN)
                illegalInstr == $past(instrValid && !legalOp))
                else $error("illegal pulse timing wrong");

        // ************************************************************
        // r0 is never written
        // ************************************************************
        aTraceNoR0: assert property (@(posedge Clk) disable iff (!rstN)
                wbWrEn |-> (wbReg != '0))
                else $error("trace marks a write to r0");

        aPortNoR0: assert property (@(posedge Clk) disable iff (!rstN)
                regWrite |-> (wrtReg != '0))
                else $error("register file write to r0");

endmodule

bind sdlxCore sdlxCore_sva uSva (
        .Clk(Clk),
        .rstN(rstN),
        .instr(instr),
        .instrValid(instrValid),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .wbWrEn(wbTrace.wrEn),
        .illegalInstr(illegalInstr),
        .regWrite(regWrite),
        .wrtReg(wrtReg)
);

/* test/tbSdlxCore.sv */
`timescale 1ns/1ps
`include "sdlx_macros.svh"

module tbSdlxCore;

        import sdlxIsaPkg::*;
        import sdlxPipePkg::*;

        // one predicted trace and the cycle it must show up in
        typedef struct packed {
                logic [31:0] due;
                wbTrace_t    tr;
        } expTrace_t;

        logic                       Clk;
        logic                       rstN;
        logic [`SDLX_DATA_BITS-1:0] instr;
        logic                       instrValid;
        logic                       wbValid;
        logic [`SDLX_REG_BITS-1:0]  wbReg;
        logic [`SDLX_DATA_BITS-1:0] wbData;
        logic                       illegalInstr;

        // reference register model and pending expectations
        logic [`SDLX_DATA_BITS-1:0] refRegs [`SDLX_NUM_REGS];
        expTrace_t                  expQ [$];
        logic [31:0]                illQ [$];
        logic [31:0]                cyc;
        integer                     seed;
        int                         errCount;

        sdlxCore i_dut (
                .Clk(Clk),
                .rstN(rstN),
                .instr(instr),
                .instrValid(instrValid),
                .wbValid(wbValid),
                .wbReg(wbReg),
                .wbData(wbData),
                .illegalInstr(illegalInstr)
        );

        // 40 ns period
        initial Clk = 1'b0;
        always #20 Clk = ~Clk;

        // cycle count, read only away from the rising edge
        initial cyc = '0;
        always @(posedge Clk) cyc <= cyc + 32'd1;

        // ************************************************************
        // failure reporting and the compare task
        // ************************************************************
        task automatic reportFailure(input string line);
                errCount++;
                $display("%s", line);
                $display(">>> FAIL");
                $fatal(1, "run stopped at the first error");
        endtask

        task automatic checkEq(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
                if (got !== exp) begin
                        reportFailure($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                                $time, name, got, exp));
                end
        endtask

        // ************************************************************
        // reference model
        // ************************************************************

        // codes 0x01..0x0A are defined, everything else traps
        function automatic logic isLegal(input logic [5:0] op);
                return (op >= 6'h01) && (op <= 6'h0A);
        endfunction

        function automatic logic [31:0] refResult(input logic [5:0] op,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b,
                                                  input logic [15:0] imm);
                logic [31:0] r;
                case (op)
                        opAdd:   r = a + b;
                        opSub:   r = a - b;
                        opAnd:   r = a & b;
                        opOr:    r = a | b;
                        opXor:   r = a ^ b;
                        opSlt:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        // only the low five bits of b count
                        opSll:   r = a << b[4:0];
                        opSrl:   r = a >> b[4:0];
                        opAddi:  r = a + {{16{imm[15]}}, imm};
                        opLhi:   r = {imm, 16'h0000};
                        default: r = 32'd0;
                endcase
                return r;
        endfunction

        // ************************************************************
        // stimulus
        // ************************************************************

        // one instruction per call, model updated in program order
        task automatic issue(input logic [5:0] op, input logic [2:0] rd,
                             input logic [2:0] rs1, input logic [2:0] rs2,
                             input logic [15:0] imm);
                expTrace_t   e;
                logic [31:0] res;
                @(posedge Clk);
                #2;
                instr      = {op, rd, rs1, rs2, 1'b0, imm};
                instrValid = 1'b1;
                if (isLegal(op)) begin
                        res        = refResult(op, refRegs[rs1], refRegs[rs2], imm);
                        e.due      = cyc + 32'd3;
                        e.tr.valid = 1'b1;
                        e.tr.rd    = rd;
                        e.tr.wrEn  = (rd != 3'd0);
                        e.tr.value = res;
                        expQ.push_back(e);
                        if (rd != 3'd0) begin
                                refRegs[rd] = res;
                        end
                end else begin
                        // pulse one edge after sampling
                        illQ.push_back(cyc + 32'd1);
                end
        endtask

        // invalid cycles carry random junk, opcode included
        task automatic idleCycles(input int n);
                for (int i = 0; i < n; i++) begin
                        @(posedge Clk);
                        #2;
                        instrValid = 1'b0;
                        instr      = $random(seed);
                end
        endtask

        task automatic drainPipe();
                int waited;
                waited = 0;
                idleCycles(1);
                while ((expQ.size() != 0) || (illQ.size() != 0)) begin
                        @(posedge Clk);
                        waited++;
                        if (waited > 10) begin
                                reportFailure("pipeline did not drain within 10 cycles");
                        end
                end
        endtask

        // r[i] = r0 + r[i], the trace shows each value
        task automatic readAll();
                for (int r = 0; r < `SDLX_NUM_REGS; r++) begin
                        issue(opAdd, 3'(r), 3'd0, 3'(r), 16'h0000);
                end
                drainPipe();
        endtask

        // ************************************************************
        // trace and illegal pulse monitor, sampled on the falling edge
        // ************************************************************
        always @(negedge Clk) begin
                expTrace_t e;
                logic      expIll;
                if (rstN) begin
                        expIll = 1'b0;
                        if ((illQ.size() != 0) && (illQ[0] == cyc)) begin
                                expIll = 1'b1;
                                void'(illQ.pop_front());
                        end
                        checkEq("illegalInstr", 32'(illegalInstr), 32'(expIll));
                        if (wbValid) begin
                                if (expQ.size() == 0) begin
                                        reportFailure("trace seen with no instruction pending");
                                end else begin
                                        e = expQ.pop_front();
                                        checkEq("trace cycle", cyc, e.due);
                                        checkEq("wbReg", 32'(wbReg), 32'(e.tr.rd));
                                        checkEq("wbData", wbData, e.tr.value);
                                        checkEq("trace wrEn", 32'(i_dut.wbTrace.wrEn),
                                                32'(e.tr.wrEn));
                                end
                        end else if ((expQ.size() != 0) && (expQ[0].due == cyc)) begin
                                reportFailure("expected trace did not appear");
                        end
                end
        end

        // ************************************************************
        // directed tests
        // ************************************************************
        task automatic testReset();
                // no trace and no trap while idle
                idleCycles(6);
                readAll();
        endtask

        task automatic testImmediates();
                issue(opAddi, 3'd1, 3'd0, 3'd0, 16'h7fff);
                // negative immediates sign extend
                issue(opAddi, 3'd2, 3'd0, 3'd0, 16'h8000);
                issue(opAddi, 3'd3, 3'd0, 3'd0, 16'hffff);
                issue(opLhi,  3'd4, 3'd0, 3'd0, 16'h1234);
                issue(opLhi,  3'd5, 3'd0, 3'd0, 16'h8001);
                issue(opAddi, 3'd6, 3'd4, 3'd0, 16'h5678);
                issue(opAddi, 3'd7, 3'd3, 3'd0, 16'h0001);
                drainPipe();
                readAll();
        endtask

        task automatic testAluOps();
                logic [5:0] ops [8];
                ops = '{opAdd, opSub, opAnd, opOr, opXor, opSlt, opSll, opSrl};
                for (int round = 0; round < 4; round++) begin
                        // full 32 bit operands from lhi then addi
                        issue(opLhi,  3'd1, 3'd0, 3'd0, 16'($random(seed)));
                        issue(opAddi, 3'd1, 3'd1, 3'd0, 16'($random(seed)));
                        issue(opLhi,  3'd2, 3'd0, 3'd0, 16'($random(seed)));
                        issue(opAddi, 3'd2, 3'd2, 3'd0, 16'($random(seed)));
                        for (int k = 0; k < 8; k++) begin
                                issue(ops[k], 3'(3 + (k % 5)), 3'd1, 3'd2, 16'h0000);
                        end
                        drainPipe();
                end
                // slt with a negative a, then the other way round
                issue(opAddi, 3'd1, 3'd0, 3'd0, 16'hfff0);
                issue(opAddi, 3'd2, 3'd0, 3'd0, 16'h0010);
                issue(opSlt,  3'd3, 3'd1, 3'd2, 16'h0000);
                issue(opSlt,  3'd4, 3'd2, 3'd1, 16'h0000);
                // shift amount 0x25 uses only 5
                issue(opAddi, 3'd5, 3'd0, 3'd0, 16'h0025);
                issue(opSll,  3'd6, 3'd2, 3'd5, 16'h0000);
                issue(opSrl,  3'd7, 3'd1, 3'd5, 16'h0000);
                drainPipe();
        endtask

        task automatic testForwarding();
                issue(opAddi, 3'd1, 3'd0, 3'd0, 16'h0007);
                issue(opAdd,  3'd2, 3'd1, 3'd1, 16'h0000);
                issue(opSub,  3'd3, 3'd2, 3'd1, 16'h0000);
                issue(opXor,  3'd4, 3'd1, 3'd3, 16'h0000);
                issue(opSll,  3'd5, 3'd3, 3'd1, 16'h0000);
                issue(opAddi, 3'd5, 3'd5, 3'd0, 16'hfff0);
                issue(opOr,   3'd6, 3'd5, 3'd4, 16'h0000);
                issue(opAdd,  3'd5, 3'd6, 3'd5, 16'h0000);
                // both levels hold r7, the newer one must win
                issue(opAddi, 3'd7, 3'd0, 3'd0, 16'h0001);
                issue(opAddi, 3'd7, 3'd0, 3'd0, 16'h0002);
                issue(opAdd,  3'd6, 3'd7, 3'd7, 16'h0000);
                drainPipe();
                readAll();
        endtask

        task automatic testRegZero();
                issue(opAddi, 3'd0, 3'd0, 3'd0, 16'h1234);
                // r0 must not be forwarded from either level
                issue(opAdd,  3'd5, 3'd0, 3'd0, 16'h0000);
                issue(opOr,   3'd6, 3'd0, 3'd0, 16'h0000);
                issue(opLhi,  3'd0, 3'd0, 3'd0, 16'hbeef);
                drainPipe();
                readAll();
        endtask

        task automatic testIllegal();
                issue(opAddi, 3'd1, 3'd0, 3'd0, 16'h0055);
                issue(6'h00,  3'd1, 3'd1, 3'd1, 16'hffff);
                issue(6'h0B,  3'd2, 3'd1, 3'd1, 16'h1111);
                issue(opAdd,  3'd3, 3'd1, 3'd1, 16'h0000);
                issue(6'h3F,  3'd3, 3'd0, 3'd0, 16'h2222);
                drainPipe();
                issue(6'h20,  3'd7, 3'd7, 3'd7, 16'h7777);
                drainPipe();
                // model skipped the illegal ones, registers must agree
                readAll();
        endtask

        initial begin
                seed       = 32'hb91d6eb1;
                errCount   = 0;
                rstN       = 1'b0;
                instr      = '0;
                instrValid = 1'b0;
                for (int r = 0; r < `SDLX_NUM_REGS; r++) begin
                        refRegs[r] = '0;
                end
                repeat (4) @(posedge Clk);
                #2;
                rstN = 1'b1;

                testReset();
                testImmediates();
                testAluOps();
                testForwarding();
                testRegZero();
                testIllegal();

                if (errCount == 0) begin
                        $display(">>> PASS");
                end else begin
                        $display(">>> FAIL");
                end
                $finish;
        end

endmodule

/* list.f */
+incdir+common
common/sdlxIsaPkg.sv
common/sdlxPipePkg.sv
regFile/regFile.sv
logic/instDecode.sv
logic/aluExec.sv
logic/resultWrite.sv
logic/sdlxCore.sv
test/sdlxCore_sva.sv
test/tbSdlxCore.sv

/* Makefile */
TOP = tbSdlxCore

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o simv
	./obj_dir/simv > sim.log 2>&1 || true
	cat sim.log
	@if grep -q ">>> FAIL" sim.log; then exit 1; fi
	@grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log
